//--- Makefile
VERILATOR ?= verilator
TOP       ?= tlb_tb
FLIST     ?= la32_tlb.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- la32_tlb.f
tlb_pkg.sv
tlb_cmd_front.sv
tlb_cam.sv
tlb_xlate_check.sv
tlb_top.sv
tlb_sva.sv
tlb_tb.sv

//--- tlb_cam.sv
// TLB entry array
module tlb_cam #(
  parameter int entry_num = 16
) (
  input  logic                         clk,
  input  logic                         rst_n,
  // associative search
  input  logic                         srch_valid,
  input  logic [tlb_pkg::valen-1:0]    srch_va,
  input  logic [tlb_pkg::asid_w-1:0]   srch_asid,
  // maintenance
  input  logic                         rd_valid,
  input  logic                         wr_valid,
  input  logic                         inv_valid,
  input  logic [tlb_pkg::idx_w-1:0]    idx,
  input  tlb_pkg::tlb_entry_t          wr_entry,
  input  tlb_pkg::tlb_inv_op_e         inv_op,
  input  logic [tlb_pkg::asid_w-1:0]   inv_asid,
  input  logic [tlb_pkg::vppn_w-1:0]   inv_vppn,
  // registered results
  output tlb_pkg::tlb_search_rsp_t     search_rsp,
  output tlb_pkg::tlb_entry_t          rd_entry
);

  tlb_pkg::tlb_entry_t [entry_num-1:0] entries;

  logic [entry_num-1:0]          match;
  logic [entry_num-1:0]          inv_hit;
  tlb_pkg::tlb_entry_t           hit_entry;
  logic [tlb_pkg::idx_w-1:0]     hit_idx;
  logic                          parity;
  logic [tlb_pkg::vppn_w-1:0]    srch_vppn;

  assign srch_vppn = srch_va[tlb_pkg::valen-1:13];

  // 4 MB pages ignore vppn bits below va[22]
  function automatic logic vppn_hit(tlb_pkg::tlb_entry_t e, logic [tlb_pkg::vppn_w-1:0] vppn);
    if (e.page_size == tlb_pkg::ps_4k) begin
      return e.vppn == vppn;
    end
    return e.vppn[tlb_pkg::vppn_w-1:9] == vppn[tlb_pkg::vppn_w-1:9];
  endfunction

  // ==============================
  // associative search
  // ==============================
  always_comb begin
    hit_entry = '0;
    hit_idx   = '0;
    for (int i = 0; i < entry_num; i++) begin
      match[i] = entries[i].exist &&
                 (entries[i].glo || entries[i].asid == srch_asid) &&
                 vppn_hit(entries[i], srch_vppn);
      // entries are assumed unique, so an OR mux is enough
      if (match[i]) begin
        hit_entry = hit_entry | entries[i];
        hit_idx   = hit_idx | tlb_pkg::idx_w'(i);
      end
    end
  end

  // odd/even half picked by the bit just above the page offset
  assign parity = (hit_entry.page_size == tlb_pkg::ps_4k) ? srch_va[12] : srch_va[21];

  // ==============================
  // invalidate select
  // ==============================
  always_comb begin
    for (int i = 0; i < entry_num; i++) begin
      case (inv_op)
        tlb_pkg::inv_all0,
        tlb_pkg::inv_all1:      inv_hit[i] = 1'b1;
        tlb_pkg::inv_glo1:      inv_hit[i] = entries[i].glo;
        tlb_pkg::inv_glo0:      inv_hit[i] = !entries[i].glo;
        tlb_pkg::inv_glo0_asid: inv_hit[i] = !entries[i].glo && entries[i].asid == inv_asid;
        tlb_pkg::inv_glo0_asid_va: begin
          inv_hit[i] = !entries[i].glo && entries[i].asid == inv_asid &&
                       vppn_hit(entries[i], inv_vppn);
        end
        // global entries or matching asid, both qualified by address
        tlb_pkg::inv_glo1_asid_va: begin
          inv_hit[i] = (entries[i].glo || entries[i].asid == inv_asid) &&
                       vppn_hit(entries[i], inv_vppn);
        end
        default: inv_hit[i] = 1'b0;
      endcase
    end
  end

  // ==============================
  // entry update
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      entries <= '0;
    end else if (wr_valid) begin
      if (idx < entry_num) begin
        entries[idx] <= wr_entry;
      end
    end else if (inv_valid) begin
      for (int i = 0; i < entry_num; i++) begin
        if (inv_hit[i]) begin
          entries[i] <= '0;
        end
      end
    end
  end

  // ==============================
  // registered results
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      search_rsp <= '0;
      rd_entry   <= '0;
    end else begin
      if (srch_valid) begin
        search_rsp.found     <= |match;
        search_rsp.idx       <= hit_idx;
        search_rsp.page_size <= hit_entry.page_size;
        search_rsp.page      <= hit_entry.page[parity];
      end
      // out of range index reads back empty
      if (rd_valid) begin
        rd_entry <= (idx < entry_num) ? entries[idx] : '0;
      end
    end
  end

endmodule

//--- tlb_cmd_front.sv
// TLB command front end
module tlb_cmd_front (
  input  logic                            clk,
  input  logic                            rst_n,
  input  tlb_pkg::tlb_lookup_req_t        lookup,
  input  tlb_pkg::tlb_maint_cmd_t         maint,
  // search request towards the CAM
  output logic                            srch_valid,
  output logic [tlb_pkg::valen-1:0]       srch_va,
  output logic [tlb_pkg::asid_w-1:0]      srch_asid,
  // maintenance strobes and operands
  output logic                            rd_valid,
  output logic                            wr_valid,
  output logic                            inv_valid,
  output logic [tlb_pkg::idx_w-1:0]       idx,
  output tlb_pkg::tlb_entry_t             wr_entry,
  output tlb_pkg::tlb_inv_op_e            inv_op,
  output logic [tlb_pkg::asid_w-1:0]      inv_asid,
  output logic [tlb_pkg::vppn_w-1:0]      inv_vppn,
  // lookup side info, one cycle behind
  output tlb_pkg::tlb_side_t              side
);

  // ==============================
  // search request
  // ==============================
  assign srch_valid = lookup.valid;
  assign srch_va    = lookup.va;
  assign srch_asid  = lookup.asid;

  // ==============================
  // maintenance decode
  // ==============================
  // at most one strobe per cycle, straight from the opcode
  always_comb begin
    rd_valid  = 1'b0;
    wr_valid  = 1'b0;
    inv_valid = 1'b0;
    case (maint.op)
      tlb_pkg::maint_read:  rd_valid  = 1'b1;
      tlb_pkg::maint_write: wr_valid  = 1'b1;
      tlb_pkg::maint_inv:   inv_valid = 1'b1;
      default: ;
    endcase
  end

  // operands go through untouched
  assign idx      = maint.idx;
  assign wr_entry = maint.entry;
  assign inv_op   = maint.inv_op;
  assign inv_asid = maint.asid;
  assign inv_vppn = maint.vppn;

  // ==============================
  // side info register
  // ==============================
  // lines up with the registered CAM result
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      side <= '0;
    end else begin
      side.valid  <= lookup.valid;
      side.va_low <= lookup.va[21:0];
      side.plv    <= lookup.plv;
      side.store  <= lookup.store;
    end
  end

endmodule

//--- tlb_pkg.sv
// TLB shared definitions
package tlb_pkg;

  // ==============================
  // widths
  // ==============================
  localparam int valen  = 32;
  localparam int palen  = 32;
  localparam int asid_w = 10;
  // virtual page pair number covers va[31:13]
  localparam int vppn_w = 19;
  localparam int ppn_w  = 20;
  // index sized for the largest supported array
  localparam int idx_w  = 4;

  // page size codes as held in an entry
  localparam logic [5:0] ps_4k = 6'd12;
  localparam logic [5:0] ps_4m = 6'd21;

  // ==============================
  // entry layout
  // ==============================
  typedef struct packed {
    logic             valid;
    logic             dirty;
    logic [1:0]       mat;
    logic [1:0]       plv;
    logic [ppn_w-1:0] ppn;
  } tlb_page_t;

  // page[0] is the even half, page[1] the odd half
  typedef struct packed {
    logic                  exist;
    logic [5:0]            page_size;
    logic                  glo;
    logic [asid_w-1:0]     asid;
    logic [vppn_w-1:0]     vppn;
    tlb_page_t [1:0]       page;
  } tlb_entry_t;

  // ==============================
  // maintenance
  // ==============================
  typedef enum logic [2:0] {
    inv_all0         = 3'd0,
    inv_all1         = 3'd1,
    inv_glo1         = 3'd2,
    inv_glo0         = 3'd3,
    inv_glo0_asid    = 3'd4,
    inv_glo0_asid_va = 3'd5,
    inv_glo1_asid_va = 3'd6,
    inv_nop          = 3'd7
  } tlb_inv_op_e;

  typedef enum logic [1:0] {
    maint_none  = 2'd0,
    maint_read  = 2'd1,
    maint_write = 2'd2,
    maint_inv   = 2'd3
  } tlb_maint_op_e;

  typedef struct packed {
    tlb_maint_op_e     op;
    logic [idx_w-1:0]  idx;
    tlb_entry_t        entry;
    tlb_inv_op_e       inv_op;
    logic [asid_w-1:0] asid;
    logic [vppn_w-1:0] vppn;
  } tlb_maint_cmd_t;

  // ==============================
  // lookup path
  // ==============================
  typedef struct packed {
    logic              valid;
    logic [valen-1:0]  va;
    logic [asid_w-1:0] asid;
    logic [1:0]        plv;
    logic              store;
  } tlb_lookup_req_t;

  typedef struct packed {
    logic             found;
    logic [idx_w-1:0] idx;
    logic [5:0]       page_size;
    tlb_page_t        page;
  } tlb_search_rsp_t;

  // offset bits up to the 4 MB boundary
  typedef struct packed {
    logic        valid;
    logic [21:0] va_low;
    logic [1:0]  plv;
    logic        store;
  } tlb_side_t;

  typedef enum logic [2:0] {
    ex_none   = 3'd0,
    ex_refill = 3'd1,
    ex_pil    = 3'd2,
    ex_pis    = 3'd3,
    ex_ppi    = 3'd4,
    ex_pme    = 3'd5
  } tlb_ecode_e;

  typedef struct packed {
    logic             valid;
    logic [palen-1:0] paddr;
    tlb_ecode_e       ecode;
    logic [idx_w-1:0] idx;
  } tlb_xlate_rsp_t;

endpackage

//--- tlb_sva.sv
// TLB top level assertions
module tlb_sva (
  input logic                     clk,
  input logic                     rst_n,
  input tlb_pkg::tlb_lookup_req_t lookup,
  input tlb_pkg::tlb_xlate_rsp_t  xlate
);

  // ==============================
  // result timing
  // ==============================
  a_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !xlate.valid)
    else $error("xlate valid while in reset");

  a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    lookup.valid |=> xlate.valid)
    else $error("no xlate one cycle after lookup");

  // ==============================
  // fault output
  // ==============================
  a_no_pa_on_fault: assert property (@(posedge clk) disable iff (!rst_n)
    xlate.ecode != tlb_pkg::ex_none |-> xlate.paddr == '0)
    else $error("paddr not zero on exception");

endmodule

bind tlb_top tlb_sva i_tlb_sva (
  .clk    (clk),
  .rst_n  (rst_n),
  .lookup (lookup),
  .xlate  (xlate)
);

//--- tlb_tb.sv
// TLB subsystem testbench
module tlb_tb;

  localparam int n_ent     = 16;
  localparam int max_cycle = 4000;

  logic                      clk;
  logic                      rst_n;
  tlb_pkg::tlb_lookup_req_t  lookup;
  tlb_pkg::tlb_maint_cmd_t   maint;
  tlb_pkg::tlb_xlate_rsp_t   xlate;
  tlb_pkg::tlb_entry_t       rd_entry;

  tlb_pkg::tlb_entry_t       model [n_ent];
  tlb_pkg::tlb_entry_t       saved [n_ent];
  integer                    seed = 72;
  int                        cycles;
  int                        checks;
  int                        errors;
  int                        test_checks;
  int                        test_errors;
  string                     test_name;

  // expected results waiting for the edge that samples the request
  logic                      pend_lk;
  tlb_pkg::tlb_xlate_rsp_t   pend_x;
  logic                      pend_rd;
  tlb_pkg::tlb_entry_t       pend_rd_e;
  logic                      cur_lk;
  tlb_pkg::tlb_xlate_rsp_t   cur_x;
  logic                      cur_rd;
  tlb_pkg::tlb_entry_t       cur_rd_e;

  tlb_top #(
    .entry_num (n_ent)
  ) i_tlb_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .lookup   (lookup),
    .maint    (maint),
    .xlate    (xlate),
    .rd_entry (rd_entry)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycle) begin
      $display("timeout after %0d cycles, DUT did not finish the test sequence", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ==============================
  // reference model
  // ==============================
  function automatic logic page_match(tlb_pkg::tlb_entry_t e, logic [18:0] vppn);
    if (e.page_size == tlb_pkg::ps_4k) begin
      return e.vppn == vppn;
    end
    return e.vppn[18:9] == vppn[18:9];
  endfunction

  function automatic tlb_pkg::tlb_xlate_rsp_t ref_xlate(logic [31:0] va, logic [9:0] asid,
                                                        logic [1:0] plv, logic st);
    tlb_pkg::tlb_xlate_rsp_t r;
    tlb_pkg::tlb_page_t      pg;
    logic                    hit;
    logic                    big;
    r       = '0;
    r.valid = 1'b1;
    hit     = 1'b0;
    big     = 1'b0;
    pg      = '0;
    for (int k = 0; k < n_ent; k++) begin
      if (!hit && model[k].exist && (model[k].glo || model[k].asid == asid) &&
          page_match(model[k], va[31:13])) begin
        hit   = 1'b1;
        r.idx = k[3:0];
        big   = model[k].page_size != tlb_pkg::ps_4k;
        pg    = model[k].page[big ? va[21] : va[12]];
      end
    end
    if (!hit) r.ecode = tlb_pkg::ex_refill;
    else if (!pg.valid) r.ecode = st ? tlb_pkg::ex_pis : tlb_pkg::ex_pil;
    else if (plv > pg.plv) r.ecode = tlb_pkg::ex_ppi;
    else if (st && !pg.dirty) r.ecode = tlb_pkg::ex_pme;
    else r.ecode = tlb_pkg::ex_none;
    if (r.ecode == tlb_pkg::ex_none) begin
      r.paddr = big ? {pg.ppn[19:9], va[20:0]} : {pg.ppn, va[11:0]};
    end
    return r;
  endfunction

  function automatic logic inv_match(tlb_pkg::tlb_entry_t e, tlb_pkg::tlb_inv_op_e op,
                                     logic [9:0] asid, logic [18:0] vppn);
    case (op)
      tlb_pkg::inv_all0, tlb_pkg::inv_all1: return 1'b1;
      tlb_pkg::inv_glo1: return e.glo;
      tlb_pkg::inv_glo0: return !e.glo;
      tlb_pkg::inv_glo0_asid: return !e.glo && e.asid == asid;
      tlb_pkg::inv_glo0_asid_va: return !e.glo && e.asid == asid && page_match(e, vppn);
      tlb_pkg::inv_glo1_asid_va: return (e.glo || e.asid == asid) && page_match(e, vppn);
      default: return 1'b0;
    endcase
  endfunction

  // ==============================
  // stimulus helpers
  // ==============================
  function automatic tlb_pkg::tlb_lookup_req_t make_lookup(logic [31:0] va, logic [9:0] asid,
                                                           logic [1:0] plv, logic st);
    tlb_pkg::tlb_lookup_req_t l;
    l.valid = 1'b1;
    l.va    = va;
    l.asid  = asid;
    l.plv   = plv;
    l.store = st;
    return l;
  endfunction

  // address inside one half of an entry with a random offset
  function automatic logic [31:0] va_for(tlb_pkg::tlb_entry_t e, logic half);
    logic [31:0] r;
    r = $random(seed);
    if (e.page_size == tlb_pkg::ps_4k) return {e.vppn, half, r[11:0]};
    return {e.vppn[18:9], half, r[20:0]};
  endfunction

  task automatic step(tlb_pkg::tlb_lookup_req_t lk, tlb_pkg::tlb_maint_cmd_t mc);
    lookup  = lk;
    maint   = mc;
    pend_lk = lk.valid;
    pend_x  = lk.valid ? ref_xlate(lk.va, lk.asid, lk.plv, lk.store) : '0;
    pend_rd = mc.op == tlb_pkg::maint_read;
    if (pend_rd) pend_rd_e = model[mc.idx];
    // model changes at the same edge as the DUT
    if (mc.op == tlb_pkg::maint_write) begin
      model[mc.idx] = mc.entry;
    end else if (mc.op == tlb_pkg::maint_inv) begin
      for (int k = 0; k < n_ent; k++) begin
        if (inv_match(model[k], mc.inv_op, mc.asid, mc.vppn)) model[k] = '0;
      end
    end
    @(posedge clk);
    #10;
  endtask

  function automatic tlb_pkg::tlb_maint_cmd_t cmd(tlb_pkg::tlb_maint_op_e op, int i,
                                                  tlb_pkg::tlb_entry_t e);
    tlb_pkg::tlb_maint_cmd_t c;
    c       = '0;
    c.op    = op;
    c.idx   = i[3:0];
    c.entry = e;
    return c;
  endfunction

  // ps_mode 0 is 4k, 1 is 4m, 2 mixed
  task automatic fill(int ps_mode, logic glo_mix, logic rnd_flags);
    tlb_pkg::tlb_entry_t e;
    logic [31:0]         r;
    for (int i = 0; i < n_ent; i++) begin
      r           = $random(seed);
      e           = '0;
      e.exist     = 1'b1;
      e.page_size = (ps_mode == 0 || (ps_mode == 2 && r[31])) ? tlb_pkg::ps_4k : tlb_pkg::ps_4m;
      e.glo       = glo_mix & i[0];
      e.asid      = i[1] ? 10'h0a6 : 10'h0a5;
      // index bits inside vppn[12:9] keep every entry unique
      e.vppn      = {r[14:9], i[3:0], r[8:0]};
      for (int h = 0; h < 2; h++) begin
        r              = $random(seed);
        e.page[h].ppn   = r[19:0];
        e.page[h].mat   = r[21:20];
        e.page[h].valid = rnd_flags ? r[22] | r[23] : 1'b1;
        e.page[h].dirty = rnd_flags ? r[24] : 1'b1;
        e.page[h].plv   = rnd_flags ? r[26:25] : 2'd3;
      end
      saved[i] = e;
      step('0, cmd(tlb_pkg::maint_write, i, e));
    end
  endtask

  task automatic lookup_all(logic foreign, logic rnd_access);
    logic [31:0] r;
    for (int i = 0; i < n_ent; i++) begin
      for (int h = 0; h < 2; h++) begin
        r = $random(seed);
        step(make_lookup(va_for(saved[i], h[0]), saved[i].asid ^ {foreign, 9'h0},
                         rnd_access ? r[1:0] : 2'd0, rnd_access ? r[2] : 1'b0), '0);
      end
    end
  endtask

  task automatic read_all();
    for (int i = 0; i < n_ent; i++) step('0, cmd(tlb_pkg::maint_read, i, '0));
  endtask

  task automatic end_test();
    step('0, '0);
    $display("test %s %0d checks, %0d errors", test_name, checks - test_checks,
             errors - test_errors);
    test_checks = checks;
    test_errors = errors;
  endtask

  // ==============================
  // comparison
  // ==============================
  task automatic report_error(string what, logic [127:0] exp, logic [127:0] act);
    errors++;
    $display("** Error %s %s: expected %h actual %h", test_name, what, exp, act);
  endtask

  always @(posedge clk) begin
    cur_lk   = pend_lk;
    cur_x    = pend_x;
    cur_rd   = pend_rd;
    cur_rd_e = pend_rd_e;
  end

  always @(negedge clk) begin
    if (rst_n) begin
      checks++;
      assert (xlate.valid == cur_lk) else report_error("valid", cur_lk, xlate.valid);
      if (cur_lk) begin
        assert (xlate.ecode == cur_x.ecode) else report_error("ecode", cur_x.ecode, xlate.ecode);
        assert (xlate.paddr == cur_x.paddr) else report_error("paddr", cur_x.paddr, xlate.paddr);
        if (cur_x.ecode != tlb_pkg::ex_refill) begin
          assert (xlate.idx == cur_x.idx) else report_error("idx", cur_x.idx, xlate.idx);
        end
      end
      if (cur_rd) begin
        assert (rd_entry == cur_rd_e) else report_error("rd_entry", cur_rd_e, rd_entry);
      end
    end
  end

  // ==============================
  // test sequence
  // ==============================
  initial begin
    tlb_pkg::tlb_maint_cmd_t c;
    clk = 0;
    rst_n = 0;
    lookup = '0;
    maint = '0;
    pend_lk = 0;
    pend_x = '0;
    pend_rd = 0;
    pend_rd_e = '0;
    for (int k = 0; k < n_ent; k++) model[k] = '0;
    repeat (5) @(posedge clk);
    #10;
    rst_n = 1;

    test_name = "write_read";
    fill(2, 1'b0, 1'b0);
    read_all();
    end_test();

    test_name = "lookup_4k";
    fill(0, 1'b0, 1'b0);
    lookup_all(1'b0, 1'b0);
    end_test();

    test_name = "lookup_4m";
    fill(1, 1'b1, 1'b0);
    lookup_all(1'b0, 1'b0);
    lookup_all(1'b1, 1'b0);
    end_test();

    test_name = "exceptions";
    fill(2, 1'b0, 1'b1);
    lookup_all(1'b0, 1'b1);
    lookup_all(1'b0, 1'b1);
    end_test();

    test_name = "invalidate";
    for (int op = 0; op < 7; op++) begin
      fill(2, 1'b1, 1'b0);
      c        = cmd(tlb_pkg::maint_inv, 0, '0);
      c.inv_op = tlb_pkg::tlb_inv_op_e'(op);
      c.asid   = 10'h0a5;
      // op 5 aims at a non-global entry, op 6 at a global one with a foreign asid
      c.vppn   = saved[op[0] ? 4 : 7].vppn;
      step('0, c);
      read_all();
      lookup_all(1'b0, 1'b0);
    end
    end_test();

    // lookup beside a write sees old contents and the next one the new
    test_name = "ordering";
    fill(0, 1'b0, 1'b0);
    step(make_lookup(va_for(saved[0], 0), saved[0].asid, 0, 0),
         cmd(tlb_pkg::maint_write, 0, saved[1]));
    step(make_lookup(va_for(saved[0], 0), saved[0].asid, 0, 0), '0);
    c        = cmd(tlb_pkg::maint_inv, 0, '0);
    c.inv_op = tlb_pkg::inv_all0;
    step(make_lookup(va_for(saved[2], 1), saved[2].asid, 0, 0), c);
    step(make_lookup(va_for(saved[2], 1), saved[2].asid, 0, 0), '0);
    end_test();

    $display("total %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- tlb_top.sv
// TLB subsystem top
module tlb_top #(
  parameter int entry_num = 16
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  tlb_pkg::tlb_lookup_req_t   lookup,
  input  tlb_pkg::tlb_maint_cmd_t    maint,
  output tlb_pkg::tlb_xlate_rsp_t    xlate,
  output tlb_pkg::tlb_entry_t        rd_entry
);

  // ==============================
  // front to CAM
  // ==============================
  logic                            srch_valid;
  logic [tlb_pkg::valen-1:0]       srch_va;
  logic [tlb_pkg::asid_w-1:0]      srch_asid;
  logic                            rd_valid;
  logic                            wr_valid;
  logic                            inv_valid;
  logic [tlb_pkg::idx_w-1:0]       idx;
  tlb_pkg::tlb_entry_t             wr_entry;
  tlb_pkg::tlb_inv_op_e            inv_op;
  logic [tlb_pkg::asid_w-1:0]      inv_asid;
  logic [tlb_pkg::vppn_w-1:0]      inv_vppn;

  // into the checker
  tlb_pkg::tlb_side_t              side;
  tlb_pkg::tlb_search_rsp_t        search_rsp;

  tlb_cmd_front i_tlb_cmd_front (
    .clk        (clk),
    .rst_n      (rst_n),
    .lookup     (lookup),
    .maint      (maint),
    .srch_valid (srch_valid),
    .srch_va    (srch_va),
    .srch_asid  (srch_asid),
    .rd_valid   (rd_valid),
    .wr_valid   (wr_valid),
    .inv_valid  (inv_valid),
    .idx        (idx),
    .wr_entry   (wr_entry),
    .inv_op     (inv_op),
    .inv_asid   (inv_asid),
    .inv_vppn   (inv_vppn),
    .side       (side)
  );

  tlb_cam #(
    .entry_num (entry_num)
  ) i_tlb_cam (
    .clk        (clk),
    .rst_n      (rst_n),
    .srch_valid (srch_valid),
    .srch_va    (srch_va),
    .srch_asid  (srch_asid),
    .rd_valid   (rd_valid),
    .wr_valid   (wr_valid),
    .inv_valid  (inv_valid),
    .idx        (idx),
    .wr_entry   (wr_entry),
    .inv_op     (inv_op),
    .inv_asid   (inv_asid),
    .inv_vppn   (inv_vppn),
    .search_rsp (search_rsp),
    .rd_entry   (rd_entry)
  );

  tlb_xlate_check i_tlb_xlate_check (
    .search_rsp (search_rsp),
    .side       (side),
    .xlate      (xlate)
  );

endmodule

//--- tlb_xlate_check.sv
// TLB translation check
module tlb_xlate_check (
  input  tlb_pkg::tlb_search_rsp_t  search_rsp,
  input  tlb_pkg::tlb_side_t        side,
  output tlb_pkg::tlb_xlate_rsp_t   xlate
);

  tlb_pkg::tlb_page_t              page;
  tlb_pkg::tlb_ecode_e             ecode;
  logic [tlb_pkg::palen-1:0]       pa_4k;
  logic [tlb_pkg::palen-1:0]       pa_4m;
  logic [tlb_pkg::palen-1:0]       pa;

  assign page = search_rsp.page;

  // ==============================
  // physical address
  // ==============================
  // 4k keeps the full ppn, 4m drops its low 9 bits
  assign pa_4k = {page.ppn, side.va_low[11:0]};
  assign pa_4m = {page.ppn[tlb_pkg::ppn_w-1:9], side.va_low[20:0]};
  assign pa    = (search_rsp.page_size == tlb_pkg::ps_4k) ? pa_4k : pa_4m;

  // ==============================
  // exception priority
  // ==============================
  always_comb begin
    if (!search_rsp.found) begin
      ecode = tlb_pkg::ex_refill;
    end else if (!page.valid) begin
      // load and store invalid split by access type
      ecode = side.store ? tlb_pkg::ex_pis : tlb_pkg::ex_pil;
    end else if (side.plv > page.plv) begin
      ecode = tlb_pkg::ex_ppi;
    end else if (side.store && !page.dirty) begin
      ecode = tlb_pkg::ex_pme;
    end else begin
      ecode = tlb_pkg::ex_none;
    end
  end

  // ==============================
  // result
  // ==============================
  always_comb begin
    xlate.valid = side.valid;
    xlate.ecode = ecode;
    xlate.idx   = search_rsp.idx;
    // no address leaks out on a fault
    if (ecode == tlb_pkg::ex_none) begin
      xlate.paddr = pa;
    end else begin
      xlate.paddr = '0;
    end
  end

endmodule
